// File: hw/ptw_defs.svh
// widths and PTE bit positions for the Sv39 page table walker
// include wherever a width or a flag index is needed

`ifndef PTW_DEFS_SVH
`define PTW_DEFS_SVH

// ------------------------------
// address and field widths
// ------------------------------
`define VADDR_W 39
`define PADDR_W 56
`define PPN_W 44
`define VPN_W 9
`define OFFSET_W 12
`define PTE_WIDTH 64
`define ID_W 4

// ------------------------------
// PTE layout
// ------------------------------
// flag bits, RSW/D/A/G/U are not looked at
`define PTE_V 0
`define PTE_R 1
`define PTE_W 2
`define PTE_X 3
`define PTE_PPN_LSB 10
// 8-byte entries
`define PTE_ENTRY_SHIFT 3

`endif

// File: hw/sv39_pkg.sv
// vector types for Sv39 addresses and page table entries
// import where an address, PTE or request id crosses a port

`include "ptw_defs.svh"

package sv39_pkg;

  // ------------------------------
  // addresses
  // ------------------------------
  // 39-bit virtual address, vpn2 | vpn1 | vpn0 | offset
  typedef logic [`VADDR_W-1:0] vaddr_t;

  // 56-bit physical address
  typedef logic [`PADDR_W-1:0] paddr_t;

  // full physical page number, ppn2 is 26 bits
  typedef logic [`PPN_W-1:0] ppn_t;

  // one of the three vpn fields
  typedef logic [`VPN_W-1:0] vpn_t;

  // offset inside a 4 KiB page
  typedef logic [`OFFSET_W-1:0] offset_t;

  // ------------------------------
  // entries and ids
  // ------------------------------
  // raw PTE as read from memory
  typedef logic [`PTE_WIDTH-1:0] pte_t;

  // tag returned with the result
  typedef logic [`ID_W-1:0] req_id_t;

endpackage

// File: hw/walk_pkg.sv
// types shared by the walk FSM and the PTE datapath
// import where the walk state, the level or a PTE class is used

package walk_pkg;

  // idle until a request, issue waits on noroom, wait_res waits on the read
  typedef enum logic [1:0] {
    idle,
    issue,
    wait_res
  } walk_state_e;

  // current level, 2 is the root, 0 the 4 KiB level
  typedef logic [1:0] level_t;

  // outcome of checking one entry
  typedef enum logic [1:0] {
    pte_fault,
    pte_leaf,
    pte_next
  } pte_class_e;

endpackage

// File: hw/walk_control.sv
// walk FSM, sequences levels 2 to 0 and issues one read per level
// ends the walk on a leaf or a fault reported by pte_checker
`timescale 1ns/10ps

module walk_control
  import walk_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       req_valid,
  input  logic       mem_noroom,
  input  logic       mem_res_valid,
  input  pte_class_e pte_class,
  output logic       busy,
  output logic       load_root,
  output logic       load_next,
  output level_t     level,
  output logic       mem_req_valid,
  output logic       res_valid,
  output logic       res_page_fault
);

  walk_state_e state;
  walk_state_e state_next;

  logic accept;
  logic launch;
  logic pte_back;
  logic walk_done;

  // ------------------------------
  // handshake decode
  // ------------------------------
  // busy is low only while idle
  assign accept = req_valid && !busy;

  // read goes out only when the port has room
  assign launch = (state == issue) && !mem_noroom;

  // entry returned for the level in flight
  assign pte_back = (state == wait_res) && mem_res_valid;

  // leaf or fault ends the walk
  assign walk_done = pte_back && (pte_class != pte_next);

  assign load_root = accept;
  assign load_next = pte_back && (pte_class == pte_next);

  // result in the same cycle as the last response
  assign res_valid = walk_done;
  assign res_page_fault = walk_done && (pte_class == pte_fault);

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (accept) begin
          state_next = issue;
        end
      end
      issue: begin
        if (launch) begin
          state_next = wait_res;
        end
      end
      wait_res: begin
        if (load_next) begin
          state_next = issue;
        end else if (walk_done) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  // ------------------------------
  // state, level, busy, read strobe
  // ------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
      level <= '0;
      busy <= 1'b0;
      mem_req_valid <= 1'b0;
    end else begin
      state <= state_next;
      // one-cycle strobe after launch
      mem_req_valid <= launch;
      // walk starts at the root level
      if (load_root) begin
        level <= level_t'(2);
      end else if (load_next) begin
        level <= level - 1'b1;
      end
      // high the cycle after accept, low the cycle after the result
      if (accept) begin
        busy <= 1'b1;
      end else if (walk_done) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// File: hw/pte_addr_gen.sv
// holds the request fields and the address of the next PTE to read
// root entry on load_root, next-level entry on load_next
`timescale 1ns/10ps

`include "ptw_defs.svh"

module pte_addr_gen
  import sv39_pkg::*;
  import walk_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    load_root,
  input  logic    load_next,
  input  level_t  level,
  input  vaddr_t  req_vaddr,
  input  ppn_t    req_root_ppn,
  input  req_id_t req_id,
  input  pte_t    mem_res_data,
  output paddr_t  pte_paddr,
  output vpn_t    vpn1,
  output vpn_t    vpn0,
  output offset_t offset,
  output req_id_t id
);

  vpn_t root_vpn;
  vpn_t next_vpn;
  ppn_t pte_ppn;

  // ------------------------------
  // address pieces
  // ------------------------------
  // vpn2 is only needed for the root read
  assign root_vpn = req_vaddr[`OFFSET_W + 2 * `VPN_W +: `VPN_W];

  // pointer at level 2 leads to vpn1, at level 1 to vpn0
  assign next_vpn = (level == level_t'(2)) ? vpn1 : vpn0;

  // ppn2..ppn0 of the returned pointer
  assign pte_ppn = mem_res_data[`PTE_PPN_LSB +: `PPN_W];

  // entry address is page base plus vpn times 8
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pte_paddr <= '0;
    end else if (load_root) begin
      pte_paddr <= {req_root_ppn, root_vpn, {`PTE_ENTRY_SHIFT{1'b0}}};
    end else if (load_next) begin
      pte_paddr <= {pte_ppn, next_vpn, {`PTE_ENTRY_SHIFT{1'b0}}};
    end
  end

  // request fields kept for the whole walk
  always_ff @(posedge clock) begin
    if (load_root) begin
      vpn1 <= req_vaddr[`OFFSET_W + `VPN_W +: `VPN_W];
      vpn0 <= req_vaddr[`OFFSET_W +: `VPN_W];
      offset <= req_vaddr[`OFFSET_W-1:0];
      id <= req_id;
    end
  end

endmodule

// File: hw/pte_checker.sv
// classifies the returned PTE as fault, leaf or pointer
// and builds the leaf physical address for the current level
`timescale 1ns/10ps

`include "ptw_defs.svh"

module pte_checker
  import sv39_pkg::*;
  import walk_pkg::*;
(
  input  pte_t       mem_res_data,
  input  level_t     level,
  input  vpn_t       vpn1,
  input  vpn_t       vpn0,
  input  offset_t    offset,
  output pte_class_e pte_class,
  output paddr_t     leaf_paddr
);

  logic pte_v;
  logic pte_r;
  logic pte_w;
  logic pte_x;
  ppn_t pte_ppn;

  assign pte_v = mem_res_data[`PTE_V];
  assign pte_r = mem_res_data[`PTE_R];
  assign pte_w = mem_res_data[`PTE_W];
  assign pte_x = mem_res_data[`PTE_X];
  assign pte_ppn = mem_res_data[`PTE_PPN_LSB +: `PPN_W];

  // ------------------------------
  // entry class
  // ------------------------------
  always_comb begin
    if (!pte_v || (pte_w && !pte_r)) begin
      // invalid, or write without read
      pte_class = pte_fault;
    end else if (pte_r || pte_x) begin
      pte_class = pte_leaf;
    end else if (level == level_t'(0)) begin
      // no level below 0
      pte_class = pte_fault;
    end else begin
      pte_class = pte_next;
    end
  end

  // ------------------------------
  // leaf address
  // ------------------------------
  // low ppn fields come from the vaddr on superpages
  always_comb begin
    case (level)
      level_t'(2): leaf_paddr = {pte_ppn[`PPN_W-1:2*`VPN_W], vpn1, vpn0, offset};
      level_t'(1): leaf_paddr = {pte_ppn[`PPN_W-1:`VPN_W], vpn0, offset};
      default: leaf_paddr = {pte_ppn, offset};
    endcase
  end

endmodule

// File: hw/page_walker.sv
// Sv39 page table walker top, one request at a time
// request side uses valid/busy, memory side valid/noroom
`timescale 1ns/10ps

module page_walker
  import sv39_pkg::*;
  import walk_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  // translation request
  input  logic    req_valid,
  input  vaddr_t  req_vaddr,
  input  ppn_t    req_root_ppn,
  input  req_id_t req_id,
  output logic    busy,
  // PTE read port
  output logic    mem_req_valid,
  output paddr_t  mem_req_paddr,
  input  logic    mem_noroom,
  input  logic    mem_res_valid,
  input  pte_t    mem_res_data,
  // translation result
  output logic    res_valid,
  output req_id_t res_id,
  output paddr_t  res_paddr,
  output logic    res_page_fault
);

  logic       load_root;
  logic       load_next;
  level_t     level;
  pte_class_e pte_class;
  paddr_t     pte_paddr;
  paddr_t     leaf_paddr;
  vpn_t       vpn1;
  vpn_t       vpn0;
  offset_t    offset;
  req_id_t    id;

  walk_control u_walk_control (
    .clock          (clock),
    .reset          (reset),
    .req_valid      (req_valid),
    .mem_noroom     (mem_noroom),
    .mem_res_valid  (mem_res_valid),
    .pte_class      (pte_class),
    .busy           (busy),
    .load_root      (load_root),
    .load_next      (load_next),
    .level          (level),
    .mem_req_valid  (mem_req_valid),
    .res_valid      (res_valid),
    .res_page_fault (res_page_fault)
  );

  pte_addr_gen u_pte_addr_gen (
    .clock        (clock),
    .reset        (reset),
    .load_root    (load_root),
    .load_next    (load_next),
    .level        (level),
    .req_vaddr    (req_vaddr),
    .req_root_ppn (req_root_ppn),
    .req_id       (req_id),
    .mem_res_data (mem_res_data),
    .pte_paddr    (pte_paddr),
    .vpn1         (vpn1),
    .vpn0         (vpn0),
    .offset       (offset),
    .id           (id)
  );

  pte_checker u_pte_checker (
    .mem_res_data (mem_res_data),
    .level        (level),
    .vpn1         (vpn1),
    .vpn0         (vpn0),
    .offset       (offset),
    .pte_class    (pte_class),
    .leaf_paddr   (leaf_paddr)
  );

  // entry address is already a register
  assign mem_req_paddr = pte_paddr;
  assign res_id = id;
  // no address on a fault
  assign res_paddr = res_page_fault ? '0 : leaf_paddr;

endmodule

// File: test/tb_page_table_model.sv
// page table memory for the walker testbench, random noroom and response latency
// tables are built at time zero, the testbench top reads them for its reference walk
`timescale 1ns/10ps

`include "ptw_defs.svh"

module tb_page_table_model
  import sv39_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] rand_word,
  input  logic        mem_req_valid,
  input  paddr_t      mem_req_paddr,
  output logic        mem_noroom,
  output logic        mem_res_valid,
  output pte_t        mem_res_data
);

  // 16 table pages at ppn 0x100..0x10f, 512 entries each
  pte_t pte_mem [0:8191];

  logic       pending;
  logic [1:0] wait_left;
  pte_t       held_data;

  // integer hash, each entry depends on its whole index
  function automatic logic [31:0] mix(input logic [31:0] n);
    logic [31:0] h;
    h = (n + 32'd1) * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    return h ^ (h >> 13);
  endfunction

  function automatic pte_t build_entry(input logic [31:0] idx);
    logic [31:0] h;
    logic [31:0] g;
    pte_t e;
    h = mix(idx);
    g = mix(idx ^ 32'h0005_5aa5);
    // reserved and A/D/G/U/RSW bits carry junk
    e = {g[31:22], h, g[11:0], g[21:16], 4'b0000};
    case (g[14:12])
      // V stays clear
      3'd0: e[`PTE_X:`PTE_R] = g[17:15];
      3'd1: begin
        // write without read
        e[`PTE_V] = 1'b1;
        e[`PTE_W] = 1'b1;
        e[`PTE_X] = g[15];
      end
      3'd5: e[`PTE_X:`PTE_V] = 4'b0011;
      3'd6: e[`PTE_X:`PTE_V] = 4'b0111;
      3'd7: e[`PTE_X:`PTE_V] = 4'b1001;
      default: begin
        // pointer into one of the table pages
        e[`PTE_V] = 1'b1;
        e[`PTE_PPN_LSB +: `PPN_W] = 44'h100 + 44'(h[3:0]);
      end
    endcase
    return e;
  endfunction

  // reads outside the table pages see an invalid entry
  function automatic pte_t fetch(input paddr_t a);
    if (a[`PADDR_W-1:16] != 40'h10) begin
      return '0;
    end
    return pte_mem[{a[15:12], a[11:3]}];
  endfunction

  initial begin
    for (int i = 0; i < 8192; i++) begin
      pte_mem[i] = build_entry(32'(i));
    end
  end

  // ------------------------------
  // read port
  // ------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mem_noroom <= 1'b0;
      mem_res_valid <= 1'b0;
      mem_res_data <= '0;
      pending <= 1'b0;
      wait_left <= '0;
      held_data <= '0;
    end else begin
      // noroom about 3 cycles in 8
      mem_noroom <= (rand_word[10:8] < 3'd3);
      mem_res_valid <= 1'b0;
      // junk on the data bus between responses
      mem_res_data <= {rand_word, ~rand_word};
      if (mem_req_valid) begin
        pending <= 1'b1;
        wait_left <= rand_word[1:0];
        held_data <= fetch(mem_req_paddr);
      end else if (pending) begin
        if (wait_left == 2'd0) begin
          mem_res_valid <= 1'b1;
          mem_res_data <= held_data;
          pending <= 1'b0;
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

endmodule

// File: test/tb_page_walker.sv
// testbench for the Sv39 page walker with random walks of every outcome over prebuilt tables
// top module of the simulation, runs with the walker RTL and the page table model
`timescale 1ns/10ps

module tb_page_walker
  import sv39_pkg::*;
();

  localparam int num_tests = 24;
  // fault outcome codes follow the leaf levels 0 to 2
  localparam int kind_bad_v = 3;
  localparam int kind_w_no_r = 4;
  localparam int kind_ptr_l0 = 5;

  logic    clock;
  logic    reset;
  logic    req_valid;
  vaddr_t  req_vaddr;
  ppn_t    req_root_ppn;
  req_id_t req_id;
  logic    busy;
  logic    mem_req_valid;
  paddr_t  mem_req_paddr;
  logic    mem_noroom;
  logic    mem_res_valid;
  pte_t    mem_res_data;
  logic    res_valid;
  req_id_t res_id;
  paddr_t  res_paddr;
  logic    res_page_fault;

  logic [31:0]  stim_state;
  logic [31:0]  mem_rand;
  paddr_t       exp_paddr;
  logic         exp_fault;
  req_id_t      exp_id;
  int           exp_reads;
  paddr_t [2:0] exp_entry_addr;
  int           read_count;
  logic         walk_open;
  logic         seen_request;
  int           error_count;

  page_walker u_page_walker (.*);

  tb_page_table_model u_page_table_model (
    .clock         (clock),
    .reset         (reset),
    .rand_word     (mem_rand),
    .mem_req_valid (mem_req_valid),
    .mem_req_paddr (mem_req_paddr),
    .mem_noroom    (mem_noroom),
    .mem_res_valid (mem_res_valid),
    .mem_res_data  (mem_res_data)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic string kind_name(input int kind);
    case (kind)
      0: return "leaf_4k";
      1: return "leaf_2m";
      2: return "leaf_1g";
      kind_bad_v: return "v_clear";
      kind_w_no_r: return "w_no_r";
      default: return "ptr_at_l0";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%s, time %0t", what, $time);
    error_count++;
  endtask

  // entry address is table page * 4096 + vpn * 8
  function automatic logic [63:0] table_entry(input logic [63:0] ppn, input logic [63:0] vpn);
    logic [63:0] addr;
    addr = ppn * 64'd4096 + vpn * 64'd8;
    return u_page_table_model.pte_mem[addr[15:3]];
  endfunction

  // ------------------------------
  // reference Sv39 walk
  // ------------------------------
  task automatic predict_walk(input vaddr_t va, input ppn_t root, output int kind,
                              output paddr_t pa, output int reads,
                              output paddr_t [2:0] addrs);
    logic [63:0] table_ppn;
    logic [63:0] pte;
    logic [63:0] vpn;
    logic [63:0] low_mask;
    int lvl;
    logic done;
    table_ppn = 64'(root);
    lvl = 2;
    done = 1'b0;
    reads = 0;
    pa = '0;
    addrs = '0;
    kind = kind_bad_v;
    while (!done) begin
      vpn = (64'(va) >> (12 + 9 * lvl)) & 64'h1ff;
      // address of the entry read at this level
      addrs[reads[1:0]] = paddr_t'(table_ppn * 64'd4096 + vpn * 64'd8);
      pte = table_entry(table_ppn, vpn);
      reads++;
      done = 1'b1;
      if (!pte[0]) begin
        kind = kind_bad_v;
      end else if (pte[2] && !pte[1]) begin
        kind = kind_w_no_r;
      end else if (pte[1] || pte[3]) begin
        // ppn above the level and vaddr below it
        low_mask = (64'd1 << (12 + 9 * lvl)) - 64'd1;
        pa = paddr_t'((((64'(pte[53:10])) >> (9 * lvl)) << (12 + 9 * lvl)) |
                      (64'(va) & low_mask));
        kind = lvl;
      end else if (lvl == 0) begin
        kind = kind_ptr_l0;
      end else begin
        table_ppn = 64'(pte[53:10]);
        lvl--;
        done = 1'b0;
      end
    end
  endtask

  // ------------------------------
  // walk tracking and assertions
  // ------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mem_rand <= 32'd36;
      walk_open <= 1'b0;
      read_count <= 0;
      seen_request <= 1'b0;
    end else begin
      mem_rand <= xorshift32(mem_rand);
      if (req_valid) begin
        seen_request <= 1'b1;
      end
      if (req_valid && !busy) begin
        walk_open <= 1'b1;
        read_count <= 0;
      end else begin
        if (res_valid) begin
          walk_open <= 1'b0;
        end
        if (mem_req_valid) begin
          read_count <= read_count + 1;
        end
      end
    end
  end

  quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
    !seen_request |-> !busy && !mem_req_valid && !res_valid)
  else report_failure("walker active before the first request");

  paddr_ok: assert property (@(posedge clock) disable iff (reset)
    res_valid |-> res_paddr == exp_paddr)
  else report_mismatch("res_paddr", $sampled(exp_paddr), $sampled(res_paddr));

  fault_ok: assert property (@(posedge clock) disable iff (reset)
    res_valid |-> res_page_fault == exp_fault)
  else report_mismatch("res_page_fault", $sampled(exp_fault), $sampled(res_page_fault));

  fault_zero_paddr: assert property (@(posedge clock) disable iff (reset)
    res_valid && res_page_fault |-> res_paddr == '0)
  else report_mismatch("res_paddr", 64'd0, $sampled(res_paddr));

  id_ok: assert property (@(posedge clock) disable iff (reset)
    res_valid |-> res_id == exp_id)
  else report_mismatch("res_id", $sampled(exp_id), $sampled(res_id));

  reads_ok: assert property (@(posedge clock) disable iff (reset)
    res_valid |-> read_count == exp_reads)
  else report_mismatch("read_count", $sampled(exp_reads), $sampled(read_count));

  // each read goes to the entry the reference walk reads at that level
  read_addr_ok: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid |-> read_count < 3 && mem_req_paddr == exp_entry_addr[read_count[1:0]])
  else report_mismatch("mem_req_paddr", $sampled(exp_entry_addr[read_count[1:0]]),
                       $sampled(mem_req_paddr));

  // launch only while noroom was low
  read_has_room: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid |-> !$past(mem_noroom))
  else report_failure("read issued after a cycle with mem_noroom high");

  read_one_cycle: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid |=> !mem_req_valid)
  else report_failure("mem_req_valid high for more than one cycle");

  res_one_cycle: assert property (@(posedge clock) disable iff (reset)
    res_valid |=> !res_valid)
  else report_failure("res_valid high for more than one cycle");

  res_with_response: assert property (@(posedge clock) disable iff (reset)
    res_valid |-> mem_res_valid)
  else report_failure("res_valid without mem_res_valid");

  busy_ok: assert property (@(posedge clock) disable iff (reset)
    busy == walk_open)
  else report_mismatch("busy", $sampled(walk_open), $sampled(busy));

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic run_test(input int n, input int kind);
    vaddr_t       va;
    ppn_t         root;
    paddr_t       pa;
    req_id_t      id;
    paddr_t [2:0] addrs;
    int got;
    int reads;
    int tries;
    int errors_before;
    errors_before = error_count;
    got = -1;
    tries = 0;
    // draw random walks until one ends in the wanted outcome
    while (got != kind && tries < 5000) begin
      stim_state = xorshift32(stim_state);
      va[31:0] = stim_state;
      stim_state = xorshift32(stim_state);
      va[38:32] = stim_state[6:0];
      root = 44'h100 + 44'(stim_state[11:8]);
      id = stim_state[15:12];
      predict_walk(va, root, got, pa, reads, addrs);
      tries++;
    end
    if (got != kind) begin
      report_failure($sformatf("no walk found that ends in %s", kind_name(kind)));
    end else begin
      repeat (stim_state[17:16]) @(posedge clock);
      @(posedge clock);
      req_valid <= 1'b1;
      req_vaddr <= va;
      req_root_ppn <= root;
      req_id <= id;
      exp_paddr <= (kind >= kind_bad_v) ? '0 : pa;
      exp_fault <= (kind >= kind_bad_v);
      exp_id <= id;
      exp_reads <= reads;
      exp_entry_addr <= addrs;
      // accepted on the edge after busy is seen low
      @(negedge clock);
      while (busy) @(negedge clock);
      @(posedge clock);
      req_valid <= 1'b0;
      // request fields move on once the walker holds its own copy
      req_vaddr <= ~va;
      req_root_ppn <= ~root;
      req_id <= ~id;
      @(negedge clock);
      while (!res_valid) @(negedge clock);
      // result edge assertions run before the report
      @(negedge clock);
      $display("test %0d %s id %0h reads %0d: %s", n, kind_name(kind), id, reads,
               (error_count == errors_before) ? "ok" : "failed");
    end
  endtask

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req_vaddr = '0;
    req_root_ppn = '0;
    req_id = '0;
    exp_paddr = '0;
    exp_fault = 1'b0;
    exp_id = '0;
    exp_reads = 0;
    exp_entry_addr = '0;
    error_count = 0;
    stim_state = 32'd36;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    // idle stretch before the first request
    repeat (6) @(posedge clock);
    for (int n = 0; n < num_tests; n++) begin
      run_test(n, n % 6);
    end
    repeat (4) @(posedge clock);
    $display("tests run %0d, checks failed %0d", num_tests, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog allows 200 cycles per test after reset
  initial begin
    repeat (16 + num_tests * 200) @(posedge clock);
    $display("watchdog expired, the walks did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: build.f
+incdir+hw
hw/sv39_pkg.sv
hw/walk_pkg.sv
hw/walk_control.sv
hw/pte_addr_gen.sv
hw/pte_checker.sv
hw/page_walker.sv
test/tb_page_table_model.sv
test/tb_page_walker.sv

// File: run_sim.sh
#!/bin/sh
# builds the page walker testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_page_walker \
  -Mdir obj_dir -o sim_page_walker \
  -f build.f

./obj_dir/sim_page_walker > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
